/* run_sim.sh */
#!/bin/sh
# build and run the tetris testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tetris_tb -o tetris_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tetris_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* source/board_pkg.sv */
`include "tetris_cfg.svh"

package board_pkg;

    // one board row
    // bit 0 is the leftmost column
    typedef logic [`TETRIS_COLS-1:0] row_t;

    // whole board, index 0 is the top row
    typedef row_t [`TETRIS_ROWS-1:0] board_t;

    // row index, wide enough for a piece box hanging below row 19
    typedef logic [4:0] row_idx_t;

    // column index, wide enough for a box hanging past column 9
    typedef logic [3:0] col_idx_t;

endpackage

/* source/game_control.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module game_control (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 drop_pulse,
    input  logic                 left_pulse,
    input  logic                 right_pulse,
    input  logic                 rotate_pulse,
    input  logic                 hit_bottom,
    input  logic                 hit_left,
    input  logic                 hit_right,
    input  board_pkg::board_t    piece_cells,
    input  piece_pkg::piece_id_t next_id,
    input  logic                 clear_done,
    input  board_pkg::board_t    cleared_board,
    output piece_pkg::piece_id_t piece_id,
    output board_pkg::row_idx_t  piece_row,
    output board_pkg::col_idx_t  piece_col,
    output board_pkg::board_t    stored_board,
    output logic                 clear_start,
    output board_pkg::board_t    display,
    output logic                 gameover
);
    import board_pkg::*;
    import piece_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_spawn, st_falling, st_rotate,
        st_stuck, st_landed, st_evaluate, st_gameover
    } state_t;

    state_t     state;
    state_t     state_next;
    // position in the spawn cycle I O S Z J L T
    logic [2:0] kind_cnt;
    // next piece loads on the way into spawn
    logic       spawn_load;
    // a landed piece reaches the top row
    logic       top_filled;

    assign spawn_load = (state == st_idle && start) || (state == st_evaluate && clear_done);
    assign top_filled = |stored_board[0];

    always_comb begin
        state_next = state;
        case (state)
            st_idle:     if (start) state_next = st_spawn;
            st_spawn:    state_next = st_falling;
            // landing beats rotation
            st_falling:  if (hit_bottom) state_next = st_stuck;
                         else if (rotate_pulse && piece_id != piece_o) state_next = st_rotate;
            st_rotate:   state_next = st_falling;
            st_stuck:    state_next = st_landed;
            st_landed:   state_next = top_filled ? st_gameover : st_evaluate;
            st_evaluate: if (clear_done) state_next = st_spawn;
            default:     state_next = st_gameover;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    // piece code, position and spawn counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            piece_id  <= piece_i;
            piece_row <= '0;
            piece_col <= col_idx_t'(`SPAWN_COL);
            kind_cnt  <= '0;
        end else if (spawn_load) begin
            piece_id  <= {2'b00, kind_cnt};
            piece_row <= '0;
            piece_col <= col_idx_t'(`SPAWN_COL);
            kind_cnt  <= (kind_cnt == 3'(`PIECE_KINDS - 1)) ? 3'd0 : kind_cnt + 3'd1;
        end else if (state == st_falling) begin
            if (drop_pulse && !hit_bottom)
                piece_row <= piece_row + 5'd1;
            // left has priority even when it is blocked
            if (left_pulse) begin
                if (!hit_left)
                    piece_col <= piece_col - 4'd1;
            end else if (right_pulse && !hit_right) begin
                piece_col <= piece_col + 4'd1;
            end
        end else if (state == st_rotate) begin
            piece_id <= next_id;
            // kick away from the contact of the old orientation
            if (hit_left)
                piece_col <= piece_col + 4'd1;
            else if (hit_right)
                piece_col <= piece_col - 4'd1;
        end
    end

    // settled cells
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            stored_board <= '0;
        else if (state == st_stuck)
            stored_board <= stored_board | piece_cells;
        else if (state == st_evaluate && clear_done)
            stored_board <= cleared_board;
    end

    assign clear_start = (state == st_landed) && !top_filled;
    assign gameover    = (state == st_gameover);

    always_comb begin
        case (state)
            st_spawn, st_falling, st_rotate, st_stuck: display = stored_board | piece_cells;
            st_evaluate: display = cleared_board;
            default:     display = stored_board;
        endcase
    end

endmodule

/* source/key_pulse.sv */
`timescale 1ns/1ps

module key_pulse (
    input  logic clk,
    input  logic reset,
    input  logic level,
    output logic pulse
);

    // two-stage synchronizer
    logic sync_0;
    logic sync_1;
    // synchronized level one cycle later, for edge detect
    logic level_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_0  <= 1'b0;
            sync_1  <= 1'b0;
            level_d <= 1'b0;
        end else begin
            sync_0  <= level;
            sync_1  <= sync_0;
            level_d <= sync_1;
        end
    end

    // one cycle on the rise only
    // a held button gives no repeat
    assign pulse = sync_1 & ~level_d;

endmodule

/* source/line_clear.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module line_clear (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  board_pkg::board_t board_in,
    output board_pkg::board_t board_out,
    output logic              done,
    output logic [7:0]        score
);
    import board_pkg::*;

    // working copy, rows removed in place
    board_t   work;
    // row under test, scan runs bottom to top
    row_idx_t row;
    // scan in progress
    logic     busy;
    // row under test is complete
    logic     row_full;

    assign row_full = busy && (&work[row]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            row   <= '0;
            done  <= 1'b0;
            score <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                row  <= row_idx_t'(`TETRIS_ROWS - 1);
            end else if (row_full) begin
                // same row again, it now holds the row from above
                if (score != 8'(`SCORE_MAX))
                    score <= score + 8'd1;
            end else if (busy) begin
                if (row == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    row <= row - 5'd1;
                end
            end
        end
    end

    // board load and row removal
    always_ff @(posedge clk) begin
        if (start) begin
            work <= board_in;
        end else if (row_full) begin
            // rows above drop by one, empty row enters on top
            for (int k = `TETRIS_ROWS - 1; k > 0; k--) begin
                if (k <= int'(row))
                    work[k] <= work[k - 1];
            end
            work[0] <= '0;
        end
    end

    assign board_out = work;

endmodule

/* source/piece_overlay.sv */
`timescale 1ns/1ps
`include "tetris_cfg.svh"

module piece_overlay (
    input  piece_pkg::pattern_t piece_pattern,
    input  board_pkg::row_idx_t piece_row,
    input  board_pkg::col_idx_t piece_col,
    input  board_pkg::board_t   stored_board,
    output board_pkg::board_t   piece_cells,
    output logic                hit_bottom,
    output logic                hit_left,
    output logic                hit_right
);

    always_comb begin
        // board position of the box cell under test
        int r;
        int c;
        piece_cells = '0;
        hit_bottom  = 1'b0;
        hit_left    = 1'b0;
        hit_right   = 1'b0;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                r = int'(piece_row) + i;
                c = int'(piece_col) + j;
                if (piece_pattern[i][j]) begin
                    // cells off the board are not drawn
                    if (r < `TETRIS_ROWS && c < `TETRIS_COLS)
                        piece_cells[r][c] = 1'b1;
                    // floor, or a stored cell just below
                    if (r + 1 >= `TETRIS_ROWS)
                        hit_bottom = 1'b1;
                    else if (c < `TETRIS_COLS && stored_board[r + 1][c])
                        hit_bottom = 1'b1;
                    // left wall, or a stored cell just left
                    if (c == 0)
                        hit_left = 1'b1;
                    else if (r < `TETRIS_ROWS && c <= `TETRIS_COLS &&
                             stored_board[r][c - 1])
                        hit_left = 1'b1;
                    // right wall, or a stored cell just right
                    if (c + 1 >= `TETRIS_COLS)
                        hit_right = 1'b1;
                    else if (r < `TETRIS_ROWS && stored_board[r][c + 1])
                        hit_right = 1'b1;
                end
            end
        end
    end

endmodule

/* source/piece_pkg.sv */
package piece_pkg;

    // orientation code
    // 0..6 spawn orientations, 7..18 rotated ones
    typedef logic [4:0] piece_id_t;

    // 4x4 grid, index [row][col]
    // row 0 on top, col 0 on the left
    typedef logic [3:0][3:0] pattern_t;

    // spawn orientations of the seven kinds, also the spawn order
    localparam piece_id_t piece_i = 5'd0;
    localparam piece_id_t piece_o = 5'd1;
    localparam piece_id_t piece_s = 5'd2;
    localparam piece_id_t piece_z = 5'd3;
    localparam piece_id_t piece_j = 5'd4;
    localparam piece_id_t piece_l = 5'd5;
    localparam piece_id_t piece_t = 5'd6;

    // rotated orientations
    //   7       I horizontal
    //   8       Z vertical
    //   9       S vertical
    //   10..12  J at 90, 180, 270
    //   13..15  L at 90, 180, 270
    //   16..18  T at 270, 180, 90
    // every pattern has a cell in box column 0,
    // so the box column is also the leftmost occupied column

endpackage

/* source/piece_rom.sv */
`timescale 1ns/1ps

module piece_rom (
    input  piece_pkg::piece_id_t piece_id,
    output piece_pkg::pattern_t  piece_pattern,
    output piece_pkg::piece_id_t next_id
);
    import piece_pkg::*;

    // pattern as 16 bits, row 0 in the low nibble
    // inside a nibble bit 0 is the left column
    always_comb begin
        case (piece_id)
            // I, two orientations
            piece_i: {piece_pattern, next_id} = {16'h1111, 5'd7};
            5'd7:    {piece_pattern, next_id} = {16'h000f, piece_i};
            // O stays as it is
            piece_o: {piece_pattern, next_id} = {16'h0033, piece_o};
            // S, two orientations
            piece_s: {piece_pattern, next_id} = {16'h0036, 5'd9};
            5'd9:    {piece_pattern, next_id} = {16'h0231, piece_s};
            // Z, two orientations
            piece_z: {piece_pattern, next_id} = {16'h0063, 5'd8};
            5'd8:    {piece_pattern, next_id} = {16'h0132, piece_z};
            // J, four orientations clockwise
            piece_j: {piece_pattern, next_id} = {16'h0071, 5'd10};
            5'd10:   {piece_pattern, next_id} = {16'h0113, 5'd11};
            5'd11:   {piece_pattern, next_id} = {16'h0047, 5'd12};
            5'd12:   {piece_pattern, next_id} = {16'h0322, piece_j};
            // L, four orientations clockwise
            piece_l: {piece_pattern, next_id} = {16'h0074, 5'd13};
            5'd13:   {piece_pattern, next_id} = {16'h0311, 5'd14};
            5'd14:   {piece_pattern, next_id} = {16'h0017, 5'd15};
            5'd15:   {piece_pattern, next_id} = {16'h0223, piece_l};
            // T, 0 -> 90 -> 180 -> 270
            piece_t: {piece_pattern, next_id} = {16'h0072, 5'd18};
            5'd18:   {piece_pattern, next_id} = {16'h0131, 5'd17};
            5'd17:   {piece_pattern, next_id} = {16'h0027, 5'd16};
            5'd16:   {piece_pattern, next_id} = {16'h0232, piece_t};
            // unused codes draw nothing and keep their code
            default: begin
                piece_pattern = '0;
                next_id       = piece_id;
            end
        endcase
    end

endmodule

/* source/tetris_cfg.svh */
`ifndef TETRIS_CFG_SVH
`define TETRIS_CFG_SVH

// board height in rows, row 0 at the top
`define TETRIS_ROWS 20

// board width in columns, column 0 at the left
`define TETRIS_COLS 10

// left column of the 4x4 box of a new piece
`define SPAWN_COL 3

// base kinds in the spawn cycle
`define PIECE_KINDS 7

// score saturates here
`define SCORE_MAX 255

`endif

/* source/tetris_top.sv */
`timescale 1ns/1ps

module tetris_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              drop_clk,
    input  logic              move_left,
    input  logic              move_right,
    input  logic              rotate,
    output board_pkg::board_t display,
    output logic              gameover,
    output logic [7:0]        score
);
    import board_pkg::*;
    import piece_pkg::*;

    // one-cycle strobes from the raw levels
    logic      drop_pulse;
    logic      left_pulse;
    logic      right_pulse;
    logic      rotate_pulse;
    // current piece and its table lookup
    piece_id_t piece_id;
    piece_id_t next_id;
    pattern_t  piece_pattern;
    row_idx_t  piece_row;
    col_idx_t  piece_col;
    // overlay results
    board_t    piece_cells;
    logic      hit_bottom;
    logic      hit_left;
    logic      hit_right;
    // line clear handshake-free strobes and result
    board_t    stored_board;
    board_t    cleared_board;
    logic      clear_start;
    logic      clear_done;

    key_pulse i_drop_pulse (.clk, .reset, .level(drop_clk), .pulse(drop_pulse));
    key_pulse i_left_pulse (.clk, .reset, .level(move_left), .pulse(left_pulse));
    key_pulse i_right_pulse (.clk, .reset, .level(move_right), .pulse(right_pulse));
    key_pulse i_rotate_pulse (.clk, .reset, .level(rotate), .pulse(rotate_pulse));

    piece_rom i_piece_rom (.piece_id, .piece_pattern, .next_id);

    piece_overlay i_piece_overlay (
        .piece_pattern, .piece_row, .piece_col, .stored_board,
        .piece_cells, .hit_bottom, .hit_left, .hit_right
    );

    line_clear i_line_clear (
        .clk, .reset, .start(clear_start), .board_in(stored_board),
        .board_out(cleared_board), .done(clear_done), .score
    );

    game_control i_game_control (
        .clk, .reset, .start,
        .drop_pulse, .left_pulse, .right_pulse, .rotate_pulse,
        .hit_bottom, .hit_left, .hit_right, .piece_cells, .next_id,
        .clear_done, .cleared_board,
        .piece_id, .piece_row, .piece_col, .stored_board, .clear_start,
        .display, .gameover
    );

endmodule

/* testbench/tetris_chk.sv */
`timescale 1ns/1ps

module tetris_chk (
    input logic       clk,
    input logic       reset,
    input logic       clear_start,
    input logic       gameover,
    input logic [7:0] score
);

    // line clear request lasts one cycle only
    a_clear_start_pulse: assert property (@(posedge clk) disable iff (reset)
        clear_start |=> !clear_start)
        else $error("clear_start high for two cycles in a row");

    // game over is sticky until reset
    a_gameover_held: assert property (@(posedge clk) disable iff (reset)
        gameover |=> gameover)
        else $error("gameover fell without reset");

    // score only counts up
    a_score_rising: assert property (@(posedge clk) disable iff (reset)
        score >= $past(score))
        else $error("score decreased");

endmodule

/* testbench/tetris_stimulus.txt */
# one command per line: start, drop n, left n, right n, rotate n, settle
# expect row <index> <hex row>, expect score <n>, expect gameover <0 or 1>
expect row 0 000
expect score 0
expect gameover 0
left 1
drop 1
expect row 0 000
start
expect row 0 008
expect row 3 008
drop 1
expect row 0 000
expect row 4 008
left 5
expect row 1 001
right 11
expect row 1 200
left 7
rotate 1
expect row 1 03c
rotate 1
expect row 4 004
rotate 1
drop 18
settle
expect row 19 03c
rotate 1
expect row 0 018
right 5
drop 18
settle
left 3
drop 18
settle
right 2
drop 18
settle
expect score 1
expect row 19 366
expect row 0 008
drop 200
settle
expect gameover 1
expect row 18 038
left 1
rotate 1
drop 2
expect row 19 366
expect score 1
expect gameover 1

/* testbench/tetris_tb.sv */
`timescale 1ns/1ps

module tetris_tb;
    import board_pkg::*;

    logic       clk;
    logic       reset;
    logic       start;
    logic       drop_clk;
    logic       move_left;
    logic       move_right;
    logic       rotate;
    board_t     display;
    logic       gameover;
    logic [7:0] score;

    // stimulus lines, comments already dropped
    string lines[$];
    int    pass_cnt;
    int    fail_cnt;
    int    cycle_cnt;
    // 0 until the stimulus file has been sized
    int    cycle_limit;

    tetris_top i_tetris_top (
        .clk, .reset, .start, .drop_clk, .move_left, .move_right, .rotate,
        .display, .gameover, .score
    );

    bind tetris_top tetris_chk i_tetris_chk (
        .clk(clk), .reset(reset), .clear_start(clear_start),
        .gameover(gameover), .score(score)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout, no progress after %0d cycles", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic void set_button(input string name, input logic value);
        case (name)
            "left":   move_left = value;
            "right":  move_right = value;
            "rotate": rotate = value;
            "drop":   drop_clk = value;
            default:  ;
        endcase
    endfunction

    // n presses, each high then low for half cycles, random idle after
    task automatic press(input string name, input int n, input int half);
        for (int k = 0; k < n; k++) begin
            set_button(name, 1'b1);
            repeat (half) @(negedge clk);
            set_button(name, 1'b0);
            repeat (half) @(negedge clk);
            repeat ($urandom_range(4)) @(negedge clk);
        end
    endtask

    task automatic compare(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_cnt++;
        end else begin
            $display("ok: %s = %h", what, got);
            pass_cnt++;
        end
    endtask

    // new piece in row 0, or game over
    task automatic settle();
        int n;
        n = 0;
        while (display[0] == '0 && !gameover && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (n >= 64) begin
            $display("settle: no new piece and no game over within 64 cycles");
            fail_cnt++;
        end
    endtask

    task automatic run_command(input string line);
        string w0;
        string w1;
        string w2;
        string w3;
        int    idx;
        void'($sscanf(line, "%s %s %s %s", w0, w1, w2, w3));
        case (w0)
            "start": begin
                start = 1'b1;
                repeat (2) @(negedge clk);
                start = 1'b0;
                repeat (2) @(negedge clk);
            end
            "drop":                   press("drop", w1.atoi(), 4);
            "left", "right", "rotate": press(w0, w1.atoi(), 3);
            "settle":                 settle();
            "expect": begin
                if (w1 == "row") begin
                    idx = w2.atoi();
                    compare($sformatf("display[%0d]", idx), int'(display[idx]), w3.atohex());
                end else if (w1 == "score") begin
                    compare("score", int'(score), w2.atoi());
                end else begin
                    compare("gameover", int'(gameover), w2.atoi());
                end
            end
            default: begin
                $display("unknown command in stimulus file: %s", w0);
                fail_cnt++;
            end
        endcase
    endtask

    // load commands, size the watchdog from their lengths
    task automatic read_stimulus();
        int    fd;
        int    budget;
        string line;
        string w0;
        string w1;
        fd = $fopen("testbench/tetris_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/tetris_stimulus.txt");
            fail_cnt++;
        end else begin
            budget = 16 + 64;
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line.getc(0) == 8'h23)
                    continue;
                lines.push_back(line);
                // a one-word command has no count
                w1 = "";
                void'($sscanf(line, "%s %s", w0, w1));
                // a press or drop period is at most 12 cycles
                budget += 64 + w1.atoi() * 16;
            end
            $fclose(fd);
            cycle_limit = budget;
        end
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        drop_clk    = 1'b0;
        move_left   = 1'b0;
        move_right  = 1'b0;
        rotate      = 1'b0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        void'($urandom(32'h365d_2314));
        read_stimulus();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (lines[i])
            run_command(lines[i]);
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && lines.size() > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/board_pkg.sv
source/piece_pkg.sv
source/key_pulse.sv
source/piece_rom.sv
source/piece_overlay.sv
source/line_clear.sv
source/game_control.sv
source/tetris_top.sv
testbench/tetris_chk.sv
testbench/tetris_tb.sv
